// ==== source/rv_slice_macros.svh ====
`ifndef RV_SLICE_MACROS_SVH
`define RV_SLICE_MACROS_SVH

// data path width and number of general registers.
`define XLEN 32
`define NREG 32

// machine CSR addresses.
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// mcause codes written on trap entry.
`define CAUSE_ILLEGAL 32'd2
`define CAUSE_BREAK   32'd3
`define CAUSE_ECALL   32'd11

`endif

// ==== source/rv_slice_pkg.sv ====
`include "rv_slice_macros.svh"

package rv_slice_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_op_e;

    typedef enum logic [3:0] {
        INSTR_ALU, INSTR_JAL, INSTR_JALR, INSTR_BRANCH, INSTR_CSR,
        INSTR_ECALL, INSTR_MRET, INSTR_EBREAK, INSTR_ILLEGAL
    } instr_kind_e;

    typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET} csr_cmd_e;

    // everything the execute unit needs to know about one instruction.
    typedef struct packed {
        instr_kind_e      kind;
        alu_op_e          alu_op;
        br_op_e           br_op;
        csr_cmd_e         csr_cmd;
        logic [4:0]       rd;
        logic             gpr_we;
        logic             src1_is_pc;
        logic             src2_is_imm;
        logic [`XLEN-1:0] imm;
        logic [11:0]      csr_addr;
        logic [`XLEN-1:0] pc;
    } decoded_t;

    typedef enum logic [1:0] {DEC_IDLE, DEC_ISSUE, DEC_WAIT_DONE, DEC_RELEASE} dec_state_e;

    typedef enum logic [1:0] {EXE_IDLE, EXE_REPORT, EXE_FINISH} exe_state_e;

endpackage

// ==== source/dec_exec_if.sv ====
`include "rv_slice_macros.svh"

interface dec_exec_if import rv_slice_pkg::*; ();

    // four-phase pair. req rises with the payload stable and ack rises
    // once the instruction has retired and its result was taken.
    logic             req;
    logic             ack;
    decoded_t         dec;
    // src2 holds the old CSR value for CSR instructions.
    logic [`XLEN-1:0] src1;
    logic [`XLEN-1:0] src2;

    modport decoder (
        output req, dec, src1, src2,
        input  ack
    );

    modport executor (
        input  req, dec, src1, src2,
        output ack
    );

endinterface

// ==== source/instr_decoder.sv ====
`include "rv_slice_macros.svh"

module instr_decoder import rv_slice_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_req,
    output logic             in_ack,
    input  logic [`XLEN-1:0] in_pc,
    input  logic [`XLEN-1:0] in_instr,
    output logic [4:0]       rs1_addr,
    output logic [4:0]       rs2_addr,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    output logic [11:0]      csr_raddr,
    input  logic [`XLEN-1:0] csr_rdata,
    dec_exec_if.decoder      dx
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_i, imm_b, imm_u, imm_j;
    logic             r_legal, i_legal;
    alu_op_e          arith_op;
    decoded_t         d;
    dec_state_e       state;

    assign opcode    = in_instr[6:0];
    assign funct3    = in_instr[14:12];
    assign funct7    = in_instr[31:25];
    assign rs1_addr  = in_instr[19:15];
    assign rs2_addr  = in_instr[24:20];
    assign csr_raddr = in_instr[31:20];

    assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]};
    assign imm_b = {{20{in_instr[31]}}, in_instr[7], in_instr[30:25], in_instr[11:8], 1'b0};
    assign imm_u = {in_instr[31:12], 12'b0};
    assign imm_j = {{12{in_instr[31]}}, in_instr[19:12], in_instr[20], in_instr[30:21], 1'b0};

    // only sub and sra may set funct7 bit 5, and slli needs funct7 of zero.
    assign r_legal = (funct7 == 7'h00) || (funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5));
    assign i_legal = (funct3 == 3'd1) ? (funct7 == 7'h00) :
                     (funct3 != 3'd5 || funct7 == 7'h00 || funct7 == 7'h20);

    // opcode bit 5 separates register-register from immediate forms.
    always_comb begin
        case (funct3)
            3'd0:    arith_op = (opcode[5] && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'd1:    arith_op = ALU_SLL;
            3'd2:    arith_op = ALU_SLT;
            3'd3:    arith_op = ALU_SLTU;
            3'd4:    arith_op = ALU_XOR;
            3'd5:    arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'd6:    arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        d          = '0;
        d.kind     = INSTR_ILLEGAL;
        d.alu_op   = ALU_ADD;
        d.br_op    = BR_NONE;
        d.csr_cmd  = CSR_NONE;
        d.rd       = in_instr[11:7];
        d.csr_addr = in_instr[31:20];
        d.pc       = in_pc;
        case (opcode)
            7'h33: if (r_legal) begin
                d.kind   = INSTR_ALU;
                d.alu_op = arith_op;
                d.gpr_we = 1'b1;
            end
            7'h13: if (i_legal) begin
                d.kind        = INSTR_ALU;
                d.alu_op      = arith_op;
                d.gpr_we      = 1'b1;
                d.src2_is_imm = 1'b1;
                d.imm         = imm_i;
            end
            7'h37, 7'h17: begin
                d.kind        = INSTR_ALU;
                d.alu_op      = opcode[5] ? ALU_PASS_B : ALU_ADD;
                d.gpr_we      = 1'b1;
                d.src1_is_pc  = !opcode[5];
                d.src2_is_imm = 1'b1;
                d.imm         = imm_u;
            end
            7'h6f: begin
                d.kind        = INSTR_JAL;
                d.gpr_we      = 1'b1;
                d.src1_is_pc  = 1'b1;
                d.src2_is_imm = 1'b1;
                d.imm         = imm_j;
            end
            7'h67: if (funct3 == 3'd0) begin
                d.kind        = INSTR_JALR;
                d.gpr_we      = 1'b1;
                d.src2_is_imm = 1'b1;
                d.imm         = imm_i;
            end
            7'h63: begin
                case (funct3)
                    3'd0:    d.br_op = BR_EQ;
                    3'd1:    d.br_op = BR_NE;
                    3'd4:    d.br_op = BR_LT;
                    3'd5:    d.br_op = BR_GE;
                    3'd6:    d.br_op = BR_LTU;
                    3'd7:    d.br_op = BR_GEU;
                    default: d.br_op = BR_NONE;
                endcase
                if (d.br_op != BR_NONE) begin
                    d.kind        = INSTR_BRANCH;
                    d.src1_is_pc  = 1'b1;
                    d.src2_is_imm = 1'b1;
                    d.imm         = imm_b;
                end
            end
            7'h73: begin
                if (funct3 == 3'd1 || funct3 == 3'd2) begin
                    d.kind    = INSTR_CSR;
                    d.gpr_we  = 1'b1;
                    d.csr_cmd = (funct3 == 3'd1) ? CSR_WRITE : CSR_SET;
                end else if (in_instr == 32'h0000_0073) begin
                    d.kind = INSTR_ECALL;
                end else if (in_instr == 32'h0010_0073) begin
                    d.kind = INSTR_EBREAK;
                end else if (in_instr == 32'h3020_0073) begin
                    d.kind = INSTR_MRET;
                end
            end
            default: ;
        endcase
        // x0 is never a write target.
        if (d.rd == 5'd0) begin
            d.gpr_we = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= DEC_IDLE;
            in_ack <= 1'b0;
            dx.req <= 1'b0;
        end else begin
            case (state)
                DEC_IDLE: if (in_req) begin
                    dx.req <= 1'b1;
                    state  <= DEC_ISSUE;
                end
                DEC_ISSUE: if (dx.ack) begin
                    dx.req <= 1'b0;
                    in_ack <= 1'b1;
                    state  <= DEC_WAIT_DONE;
                end
                DEC_WAIT_DONE: if (!dx.ack) begin
                    state <= DEC_RELEASE;
                end
                default: if (!in_req) begin
                    in_ack <= 1'b0;
                    state  <= DEC_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DEC_IDLE && in_req) begin
            dx.dec  <= d;
            dx.src1 <= rs1_data;
            dx.src2 <= (d.kind == INSTR_CSR) ? csr_rdata : rs2_data;
        end
    end

endmodule

// ==== source/reg_file.sv ====
`include "rv_slice_macros.svh"

module reg_file (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [$clog2(`NREG)-1:0] rs1_addr,
    input  logic [$clog2(`NREG)-1:0] rs2_addr,
    output logic [`XLEN-1:0]         rs1_data,
    output logic [`XLEN-1:0]         rs2_data,
    input  logic                     we,
    input  logic [$clog2(`NREG)-1:0] waddr,
    input  logic [`XLEN-1:0]         wdata
);

    logic [`XLEN-1:0] regs [`NREG];

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== source/csr_file.sv ====
`include "rv_slice_macros.svh"

module csr_file import rv_slice_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [11:0]      raddr,
    output logic [`XLEN-1:0] rdata,
    input  csr_cmd_e         csr_cmd,
    input  logic [11:0]      waddr,
    input  logic [`XLEN-1:0] wdata,
    input  logic             trap_en,
    input  logic [`XLEN-1:0] trap_cause,
    input  logic [`XLEN-1:0] trap_pc,
    input  logic             mret_en,
    output logic [`XLEN-1:0] mtvec,
    output logic [`XLEN-1:0] mepc
);

    logic [`XLEN-1:0] mstatus, mcause;
    logic [`XLEN-1:0] new_val;
    logic             wr;

    // unimplemented addresses read as zero.
    function automatic logic [`XLEN-1:0] csr_read(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS: return mstatus;
            `CSR_MTVEC:   return mtvec;
            `CSR_MEPC:    return mepc;
            `CSR_MCAUSE:  return mcause;
            default:      return '0;
        endcase
    endfunction

    assign rdata   = csr_read(raddr);
    assign new_val = (csr_cmd == CSR_SET) ? (csr_read(waddr) | wdata) : wdata;
    // a trap or a return owns the cycle, so a CSR write never lands with it.
    assign wr      = (csr_cmd != CSR_NONE) && !trap_en && !mret_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (trap_en) begin
            mepc   <= trap_pc;
            mcause <= trap_cause;
        end else if (wr) begin
            case (waddr)
                `CSR_MSTATUS: mstatus <= new_val;
                `CSR_MTVEC:   mtvec   <= new_val;
                `CSR_MEPC:    mepc    <= new_val;
                `CSR_MCAUSE:  mcause  <= new_val;
                default: ;
            endcase
        end
    end

endmodule

// ==== source/exec_unit.sv ====
`include "rv_slice_macros.svh"

module exec_unit import rv_slice_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    dec_exec_if.executor     dx,
    output logic             gpr_we,
    output logic [4:0]       gpr_waddr,
    output logic [`XLEN-1:0] gpr_wdata,
    output csr_cmd_e         csr_cmd,
    output logic [11:0]      csr_waddr,
    output logic [`XLEN-1:0] csr_wdata,
    output logic             trap_en,
    output logic [`XLEN-1:0] trap_cause,
    output logic [`XLEN-1:0] trap_pc,
    output logic             mret_en,
    input  logic [`XLEN-1:0] mtvec,
    input  logic [`XLEN-1:0] mepc,
    output logic             res_req,
    input  logic             res_ack,
    output logic [4:0]       res_rd,
    output logic             res_we,
    output logic [`XLEN-1:0] res_wdata,
    output logic [`XLEN-1:0] res_next_pc,
    output logic             res_trap
);

    decoded_t         d;
    logic [`XLEN-1:0] op_a, op_b, alu_res, pc_plus4, wdata, next_pc, cause;
    logic             taken, is_trap, fire;
    exe_state_e       state;

    assign d        = dx.dec;
    assign op_a     = d.src1_is_pc ? d.pc : dx.src1;
    assign op_b     = d.src2_is_imm ? d.imm : dx.src2;
    assign pc_plus4 = d.pc + 32'd4;

    always_comb begin
        case (d.alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // branches compare the raw register operands while the ALU forms pc+imm.
    always_comb begin
        case (d.br_op)
            BR_EQ:   taken = dx.src1 == dx.src2;
            BR_NE:   taken = dx.src1 != dx.src2;
            BR_LT:   taken = $signed(dx.src1) < $signed(dx.src2);
            BR_GE:   taken = $signed(dx.src1) >= $signed(dx.src2);
            BR_LTU:  taken = dx.src1 < dx.src2;
            BR_GEU:  taken = dx.src1 >= dx.src2;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = pc_plus4;
        is_trap = 1'b0;
        cause   = '0;
        case (d.kind)
            INSTR_JAL:    next_pc = alu_res;
            INSTR_JALR:   next_pc = {alu_res[`XLEN-1:1], 1'b0};
            INSTR_BRANCH: next_pc = taken ? alu_res : pc_plus4;
            INSTR_MRET:   next_pc = mepc;
            INSTR_ECALL, INSTR_EBREAK, INSTR_ILLEGAL: begin
                next_pc = mtvec;
                is_trap = 1'b1;
                cause   = (d.kind == INSTR_ECALL)  ? `CAUSE_ECALL :
                          (d.kind == INSTR_EBREAK) ? `CAUSE_BREAK : `CAUSE_ILLEGAL;
            end
            default: ;
        endcase
    end

    assign wdata = (d.kind == INSTR_JAL || d.kind == INSTR_JALR) ? pc_plus4 :
                   (d.kind == INSTR_CSR) ? dx.src2 : alu_res;

    // the sink must have released res_ack before a new result is taken.
    assign fire = (state == EXE_IDLE) && dx.req && !res_ack;

    assign gpr_we     = fire && d.gpr_we;
    assign gpr_waddr  = d.rd;
    assign gpr_wdata  = wdata;
    assign csr_cmd    = fire ? d.csr_cmd : CSR_NONE;
    assign csr_waddr  = d.csr_addr;
    assign csr_wdata  = dx.src1;
    assign trap_en    = fire && is_trap;
    assign trap_cause = cause;
    assign trap_pc    = d.pc;
    assign mret_en    = fire && d.kind == INSTR_MRET;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= EXE_IDLE;
            res_req <= 1'b0;
            dx.ack  <= 1'b0;
        end else begin
            case (state)
                EXE_IDLE: if (fire) begin
                    res_req <= 1'b1;
                    state   <= EXE_REPORT;
                end
                EXE_REPORT: if (res_ack) begin
                    res_req <= 1'b0;
                    dx.ack  <= 1'b1;
                    state   <= EXE_FINISH;
                end
                default: if (!dx.req) begin
                    dx.ack <= 1'b0;
                    state  <= EXE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            res_rd      <= d.rd;
            res_we      <= d.gpr_we;
            res_wdata   <= wdata;
            res_next_pc <= next_pc;
            res_trap    <= is_trap;
        end
    end

endmodule

// ==== source/rv_exec_slice.sv ====
`include "rv_slice_macros.svh"

module rv_exec_slice import rv_slice_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_req,
    output logic             in_ack,
    input  logic [`XLEN-1:0] in_pc,
    input  logic [`XLEN-1:0] in_instr,
    output logic             res_req,
    input  logic             res_ack,
    output logic [4:0]       res_rd,
    output logic             res_we,
    output logic [`XLEN-1:0] res_wdata,
    output logic [`XLEN-1:0] res_next_pc,
    output logic             res_trap
);

    logic [4:0]       rs1_addr, rs2_addr, gpr_waddr;
    logic [`XLEN-1:0] rs1_data, rs2_data, gpr_wdata;
    logic             gpr_we;
    logic [11:0]      csr_raddr, csr_waddr;
    logic [`XLEN-1:0] csr_rdata, csr_wdata;
    csr_cmd_e         csr_cmd;
    logic             trap_en, mret_en;
    logic [`XLEN-1:0] trap_cause, trap_pc, mtvec, mepc;

    dec_exec_if dx ();

    instr_decoder decoder0 (
        .clk, .rst, .in_req, .in_ack, .in_pc, .in_instr,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .csr_raddr, .csr_rdata, .dx(dx.decoder)
    );

    reg_file gpr0 (
        .clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .we(gpr_we), .waddr(gpr_waddr), .wdata(gpr_wdata)
    );

    csr_file csr0 (
        .clk, .rst, .raddr(csr_raddr), .rdata(csr_rdata),
        .csr_cmd, .waddr(csr_waddr), .wdata(csr_wdata),
        .trap_en, .trap_cause, .trap_pc, .mret_en, .mtvec, .mepc
    );

    exec_unit exec0 (
        .clk, .rst, .dx(dx.executor),
        .gpr_we, .gpr_waddr, .gpr_wdata,
        .csr_cmd, .csr_waddr, .csr_wdata,
        .trap_en, .trap_cause, .trap_pc, .mret_en, .mtvec, .mepc,
        .res_req, .res_ack, .res_rd, .res_we, .res_wdata, .res_next_pc, .res_trap
    );

endmodule

// ==== tests/rv_exec_slice_checker.sv ====
`include "rv_slice_macros.svh"

module rv_exec_slice_checker (
    input logic             clk,
    input logic             rst,
    input logic             in_ack,
    input logic             res_req,
    input logic             res_ack,
    input logic [4:0]       res_rd,
    input logic             res_we,
    input logic [`XLEN-1:0] res_next_pc,
    input logic             res_trap
);

    int fail_count = 0;

    // a result stays offered until the sink takes it.
    result_held: assert property (@(posedge clk) disable iff (rst)
        res_req && !res_ack |=> res_req)
    else begin
        fail_count++;
        $error("res_req fell before res_ack was seen");
    end

    // the instruction only retires after its result was released.
    retire_after_result: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> !res_req)
    else begin
        fail_count++;
        $error("in_ack rose while res_req was still high");
    end

    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        res_req |-> !(res_we && res_rd == 5'd0))
    else begin
        fail_count++;
        $error("result reports a write to x0");
    end

    // without compressed instructions every target is a whole word.
    pc_aligned: assert property (@(posedge clk) disable iff (rst)
        res_req && !res_trap |-> res_next_pc[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("next pc of a non-trap result is not word aligned");
    end

endmodule

bind rv_exec_slice rv_exec_slice_checker checker0 (.*);

// ==== tests/rv_exec_slice_tb.sv ====
`include "rv_slice_macros.svh"

module rv_exec_slice_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM     = 48;
    localparam int N_SLOW       = 6;
    // the directed control, CSR and trap sections stay below this count.
    localparam int N_DIRECTED   = 100;
    localparam int WATCHDOG_CYCLES = (N_RANDOM + N_SLOW + N_DIRECTED) * 200 + RESET_CYCLES;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_req, in_ack, res_req, res_ack;
    logic [31:0] in_pc, in_instr;
    logic [4:0]  res_rd;
    logic        res_we, res_trap;
    logic [31:0] res_wdata, res_next_pc;

    logic [31:0] gpr [32];
    logic [31:0] m_mstatus, m_mtvec, m_mepc, m_mcause;
    logic [31:0] cur_pc;
    int          errors, sent, max_delay;
    logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [11:0] csr_list [5] = '{`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE, 12'h7c0};

    rv_exec_slice dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the slice stopped responding after %0d instructions", sent);
        $display("TEST FAILED");
        $finish;
    end

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? (a - b) : (a + b);
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : (a >> b[4:0]);
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] csr_get(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS: return m_mstatus;
            `CSR_MTVEC:   return m_mtvec;
            `CSR_MEPC:    return m_mepc;
            `CSR_MCAUSE:  return m_mcause;
            default:      return 32'd0;
        endcase
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(15, 0));
    endfunction

    // one full four-phase exchange on both ports, then the model retires it.
    task automatic issue_instr(input logic [31:0] instr, input logic [4:0] rd, input logic we,
                               input logic [31:0] wdata, input logic [31:0] next_pc,
                               input logic trap);
        int delay;
        in_pc    = cur_pc;
        in_instr = instr;
        in_req   = 1'b1;
        while (!res_req) step_clock();
        check_val("res_we", res_we, we);
        check_val("res_trap", res_trap, trap);
        check_val("res_next_pc", res_next_pc, next_pc);
        if (we) begin
            check_val("res_rd", res_rd, rd);
            check_val("res_wdata", res_wdata, wdata);
        end
        delay = $urandom_range(max_delay, 0);
        repeat (delay) step_clock();
        res_ack = 1'b1;
        while (res_req) step_clock();
        res_ack = 1'b0;
        while (!in_ack) step_clock();
        in_req = 1'b0;
        while (in_ack) step_clock();
        if (we) begin
            gpr[rd] = wdata;
        end
        cur_pc = cur_pc + 32'd4;
        sent++;
    endtask

    task automatic alu_reg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
        logic [31:0] res;
        res = alu_ref(f3, alt, gpr[rs1], gpr[rs2]);
        issue_instr({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33}, rd, rd != 0, res,
                    cur_pc + 4, 1'b0);
    endtask

    task automatic alu_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
        logic [31:0] res;
        res = alu_ref(f3, f3 == 3'd5 && imm[10], gpr[rs1], {{20{imm[11]}}, imm});
        issue_instr({imm, rs1, f3, rd, 7'h13}, rd, rd != 0, res, cur_pc + 4, 1'b0);
    endtask

    task automatic upper(input logic is_lui, input logic [4:0] rd, input logic [19:0] imm);
        logic [31:0] res;
        res = is_lui ? {imm, 12'h000} : cur_pc + {imm, 12'h000};
        issue_instr({imm, rd, is_lui ? 7'h37 : 7'h17}, rd, rd != 0, res, cur_pc + 4, 1'b0);
    endtask

    task automatic run_random_alu(input int count);
        logic [2:0]  f3;
        logic [11:0] imm;
        int          pick;
        for (int i = 0; i < count; i++) begin
            f3   = 3'($urandom_range(7, 0));
            imm  = 12'($urandom());
            pick = $urandom_range(4, 0);
            if (f3 == 3'd1) begin
                imm = {7'h00, imm[4:0]};
            end else if (f3 == 3'd5) begin
                imm = {1'b0, imm[10], 5'h00, imm[4:0]};
            end
            if (pick < 2) begin
                alu_reg(f3, imm[10] && (f3 == 3'd0 || f3 == 3'd5), rand_reg(), rand_reg(),
                        rand_reg());
            end else if (pick < 4) begin
                alu_imm(f3, rand_reg(), rand_reg(), imm);
            end else begin
                upper(imm[0], rand_reg(), 20'($urandom()));
            end
        end
    endtask

    task automatic branch_test(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [12:0] imm;
        logic [31:0] target;
        imm      = 13'($urandom());
        imm[1:0] = 2'b00;
        target   = br_ref(f3, gpr[rs1], gpr[rs2]) ? cur_pc + {{19{imm[12]}}, imm} : cur_pc + 4;
        issue_instr({imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63}, 5'd0, 1'b0,
                    32'd0, target, 1'b0);
    endtask

    task automatic jal_test(input logic [4:0] rd);
        logic [20:0] imm;
        imm      = 21'($urandom());
        imm[1:0] = 2'b00;
        issue_instr({imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f}, rd, rd != 0,
                    cur_pc + 4, cur_pc + {{11{imm[20]}}, imm}, 1'b0);
    endtask

    task automatic jalr_test(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] target;
        target = (gpr[rs1] + {{20{imm[11]}}, imm}) & 32'hffff_fffe;
        issue_instr({imm, rs1, 3'd0, rd, 7'h67}, rd, rd != 0, cur_pc + 4, target, 1'b0);
    endtask

    task automatic csr_op(input logic set, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] addr);
        logic [31:0] old_val, src, new_val;
        old_val = csr_get(addr);
        src     = gpr[rs1];
        new_val = set ? (old_val | src) : src;
        issue_instr({addr, rs1, set ? 3'd2 : 3'd1, rd, 7'h73}, rd, rd != 0, old_val,
                    cur_pc + 4, 1'b0);
        case (addr)
            `CSR_MSTATUS: m_mstatus = new_val;
            `CSR_MTVEC:   m_mtvec   = new_val;
            `CSR_MEPC:    m_mepc    = new_val;
            `CSR_MCAUSE:  m_mcause  = new_val;
            default: ;
        endcase
    endtask

    // trap, read back mepc and mcause, then return through mret.
    task automatic trap_test(input logic [31:0] instr, input logic [31:0] cause);
        logic [31:0] trap_at;
        trap_at = cur_pc;
        issue_instr(instr, 5'd0, 1'b0, 32'd0, m_mtvec, 1'b1);
        m_mepc   = trap_at;
        m_mcause = cause;
        csr_op(1'b1, 5'd12, 5'd0, `CSR_MEPC);
        csr_op(1'b1, 5'd13, 5'd0, `CSR_MCAUSE);
        issue_instr(32'h3020_0073, 5'd0, 1'b0, 32'd0, m_mepc, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h0b2c6228));
        rst       = 1'b1;
        in_req    = 1'b0;
        in_pc     = 32'd0;
        in_instr  = 32'd0;
        res_ack   = 1'b0;
        errors    = 0;
        sent      = 0;
        max_delay = 3;
        cur_pc    = 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            gpr[i] = 32'd0;
        end
        m_mstatus = 32'd0;
        m_mtvec   = 32'd0;
        m_mepc    = 32'd0;
        m_mcause  = 32'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        step_clock();

        for (int r = 1; r < 8; r++) begin
            alu_imm(3'd0, 5'(r), 5'd0, 12'($urandom()));
        end
        upper(1'b1, 5'd8, 20'($urandom()));
        run_random_alu(N_RANDOM);

        alu_imm(3'd0, 5'd1, 5'd0, 12'h123);
        alu_imm(3'd0, 5'd2, 5'd0, 12'hffb);
        alu_imm(3'd0, 5'd3, 5'd0, 12'h007);
        for (int p = 0; p < 3; p++) begin
            for (int b = 0; b < 6; b++) begin
                branch_test(br_f3[b], (p == 0) ? 5'd1 : (p == 1) ? 5'd2 : 5'd3,
                            (p == 0) ? 5'd1 : (p == 1) ? 5'd3 : 5'd2);
            end
        end
        jal_test(5'd1);
        jal_test(5'd0);
        upper(1'b1, 5'd4, 20'h00002);
        jalr_test(5'd5, 5'd4, 12'hff8);
        jalr_test(5'd0, 5'd4, 12'h001);

        alu_imm(3'd0, 5'd0, 5'd1, 12'h005);
        alu_reg(3'd0, 1'b0, 5'd6, 5'd0, 5'd0);
        max_delay = 24;
        run_random_alu(N_SLOW);
        max_delay = 3;

        upper(1'b1, 5'd9, 20'h12345);
        alu_imm(3'd0, 5'd10, 5'd0, 12'h044);
        for (int c = 0; c < 5; c++) begin
            csr_op(1'b0, 5'd8, 5'd9, csr_list[c]);
            csr_op(1'b1, 5'd8, 5'd10, csr_list[c]);
            csr_op(1'b1, 5'd8, 5'd0, csr_list[c]);
        end
        upper(1'b1, 5'd11, 20'h00001);
        csr_op(1'b0, 5'd0, 5'd11, `CSR_MTVEC);

        // consecutive traps use different causes so each mcause update shows.
        trap_test(32'h0000_0073, `CAUSE_ECALL);
        trap_test(32'hffff_ffff, `CAUSE_ILLEGAL);
        trap_test(32'h0010_0073, `CAUSE_BREAK);
        trap_test({12'h000, 5'd1, 3'd2, 5'd5, 7'h03}, `CAUSE_ILLEGAL);

        step_clock();
        $display("%0d instructions, %0d result mismatches, %0d assertion failures",
                 sent, errors, dut0.checker0.fail_count);
        if (errors == 0 && dut0.checker0.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_exec_slice.f ====
+incdir+source
source/rv_slice_pkg.sv
source/dec_exec_if.sv
source/instr_decoder.sv
source/reg_file.sv
source/csr_file.sv
source/exec_unit.sv
source/rv_exec_slice.sv
tests/rv_exec_slice_checker.sv
tests/rv_exec_slice_tb.sv

// ==== Bender.yml ====
package:
  name: rv_exec_slice

sources:
  - include_dirs:
      - source
    files:
      - source/rv_slice_pkg.sv
      - source/dec_exec_if.sv
      - source/instr_decoder.sv
      - source/reg_file.sv
      - source/csr_file.sv
      - source/exec_unit.sv
      - source/rv_exec_slice.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/rv_exec_slice_checker.sv
      - tests/rv_exec_slice_tb.sv
